// File: rtl/fir_pkg.sv
package fir_pkg;

	// ====================================================================
	// Filter geometry
	// ====================================================================

	localparam int NUM_TAPS = 19;
	localparam int SPLIT_TAP = 10;	// First tap of the upper MAC unit.

	// ====================================================================
	// Arithmetic widths
	// ====================================================================

	localparam int SAMPLE_WIDTH = 16;
	localparam int COEF_WIDTH = 8;
	localparam int COEF_FRAC = 7;	// Coefficients are Q0.7.
	localparam int ACC_WIDTH = 32;

	typedef logic signed [COEF_WIDTH-1:0] coef_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// Symmetric low-pass set, sums to 128 for unity DC gain.
	// Entry 0 weights the newest sample.
	localparam coef_t FIR_COEFS [NUM_TAPS] = '{
		-8'sd1,
		-8'sd2,
		-8'sd2,
		8'sd0,
		8'sd4,
		8'sd8,
		8'sd13,
		8'sd16,
		8'sd18,
		8'sd20,	// Center tap.
		8'sd18,
		8'sd16,
		8'sd13,
		8'sd8,
		8'sd4,
		8'sd0,
		-8'sd2,
		-8'sd2,
		-8'sd1
	};

endpackage

// File: rtl/tap_bus_if.sv
`timescale 1ns/1ps

interface tap_bus_if #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH
);
	import fir_pkg::*;

	logic signed [WIDTH-1:0] taps [NUM_TAPS];	// Tap 0 is the newest sample.
	logic advance;	// Taps shifted on the previous edge.

	modport source (
		output taps,
		output advance
	);

	modport sink (
		input taps,
		input advance
	);

endinterface

// File: rtl/tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic signed [WIDTH-1:0] sample_in,
	input logic sample_valid,
	tap_bus_if.source taps_bus
);
	import fir_pkg::*;

	logic signed [WIDTH-1:0] tap_q [NUM_TAPS];
	logic advance_q;

	// ====================================================================
	// Shift chain
	// ====================================================================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				tap_q[i] <= '0;
			end
		end else if (sample_valid) begin
			tap_q[0] <= sample_in;
			for (int i = 1; i < NUM_TAPS; i++) begin
				tap_q[i] <= tap_q[i-1];	// Each tap takes its lower neighbor.
			end
		end
	end

	// Strobe delayed to line up with the shifted taps.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			advance_q <= 1'b0;
		end else begin
			advance_q <= sample_valid;
		end
	end

	// ====================================================================
	// Bus outputs
	// ====================================================================

	assign taps_bus.taps = tap_q;
	assign taps_bus.advance = advance_q;

endmodule

// File: rtl/partial_mac.sv
`timescale 1ns/1ps

module partial_mac #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH,
	parameter int FIRST_TAP = 0,
	parameter int TAP_COUNT = fir_pkg::NUM_TAPS
) (
	input logic clk,
	input logic reset,
	tap_bus_if.sink taps_bus,
	output fir_pkg::acc_t partial_sum,
	output logic sum_valid
);
	import fir_pkg::*;

	// Full product width of one tap times one coefficient.
	localparam int PROD_WIDTH = WIDTH + COEF_WIDTH;

	logic signed [PROD_WIDTH-1:0] prod [TAP_COUNT];
	acc_t sum_comb;

	// ====================================================================
	// Products
	// ====================================================================

	always_comb begin
		for (int k = 0; k < TAP_COUNT; k++) begin
			prod[k] = taps_bus.taps[FIRST_TAP + k] * FIR_COEFS[FIRST_TAP + k];
		end
	end

	// ====================================================================
	// Adder tree
	// ====================================================================

	// Sign-extended accumulation, no rounding at this stage.
	always_comb begin
		sum_comb = '0;
		for (int k = 0; k < TAP_COUNT; k++) begin
			sum_comb = sum_comb + acc_t'(prod[k]);
		end
	end

	// ====================================================================
	// Output register
	// ====================================================================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			partial_sum <= '0;
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= taps_bus.advance;	// One pulse per accepted sample.
			if (taps_bus.advance) begin
				partial_sum <= sum_comb;
			end
		end
	end

endmodule

// File: rtl/fir_combiner.sv
`timescale 1ns/1ps

module fir_combiner #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH
) (
	input logic clk,
	input logic reset,
	input fir_pkg::acc_t low_sum,
	input fir_pkg::acc_t high_sum,
	input logic sums_valid,
	output logic signed [WIDTH-1:0] sample_out,
	output logic out_valid
);
	import fir_pkg::*;

	// One guard bit so the sum of two partials cannot wrap.
	typedef logic signed [ACC_WIDTH:0] wide_t;

	localparam wide_t ROUND_HALF = wide_t'(1) <<< (COEF_FRAC - 1);
	localparam wide_t OUT_MAX = (wide_t'(1) <<< (WIDTH - 1)) - wide_t'(1);
	localparam wide_t OUT_MIN = -(wide_t'(1) <<< (WIDTH - 1));

	wide_t total;
	wide_t scaled;
	logic signed [WIDTH-1:0] clamped;

	// ====================================================================
	// Round and saturate
	// ====================================================================

	always_comb begin
		total = wide_t'(low_sum) + wide_t'(high_sum) + ROUND_HALF;
		scaled = total >>> COEF_FRAC;	// Drop the coefficient fraction.

		if (scaled > OUT_MAX) begin
			clamped = OUT_MAX[WIDTH-1:0];
		end else if (scaled < OUT_MIN) begin
			clamped = OUT_MIN[WIDTH-1:0];
		end else begin
			clamped = scaled[WIDTH-1:0];
		end
	end

	// ====================================================================
	// Output register
	// ====================================================================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sample_out <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= sums_valid;
			if (sums_valid) begin
				sample_out <= clamped;	// Held between results.
			end
		end
	end

endmodule

// File: rtl/fir19_top.sv
`timescale 1ns/1ps

module fir19_top #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic signed [WIDTH-1:0] sample_in,
	input logic sample_valid,
	output logic signed [WIDTH-1:0] sample_out,
	output logic out_valid
);
	import fir_pkg::*;

	acc_t low_sum;
	acc_t high_sum;
	logic low_valid;
	logic high_valid;	// Mirrors low_valid, both units share one advance.

	tap_bus_if #(.WIDTH(WIDTH)) taps_bus ();

	// ====================================================================
	// Delay line
	// ====================================================================

	tap_delay_line #(.WIDTH(WIDTH)) u_delay_line (
		.clk (clk),
		.reset (reset),
		.sample_in (sample_in),
		.sample_valid (sample_valid),
		.taps_bus (taps_bus.source)
	);

	// ====================================================================
	// MAC units
	// ====================================================================

	partial_mac #(
		.WIDTH (WIDTH),
		.FIRST_TAP (0),
		.TAP_COUNT (SPLIT_TAP)
	) u_mac_low (
		.clk (clk),
		.reset (reset),
		.taps_bus (taps_bus.sink),
		.partial_sum (low_sum),
		.sum_valid (low_valid)
	);

	partial_mac #(
		.WIDTH (WIDTH),
		.FIRST_TAP (SPLIT_TAP),
		.TAP_COUNT (NUM_TAPS - SPLIT_TAP)
	) u_mac_high (
		.clk (clk),
		.reset (reset),
		.taps_bus (taps_bus.sink),
		.partial_sum (high_sum),
		.sum_valid (high_valid)
	);

	fir_combiner #(.WIDTH(WIDTH)) u_combiner (
		.clk (clk),
		.reset (reset),
		.low_sum (low_sum),
		.high_sum (high_sum),
		.sums_valid (low_valid),
		.sample_out (sample_out),
		.out_valid (out_valid)
	);

endmodule

// File: testbench/fir19_props.sv
`timescale 1ns/1ps

module fir19_props #(
	parameter int WIDTH = fir_pkg::SAMPLE_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic out_valid,
	input logic signed [WIDTH-1:0] sample_out,
	input logic low_valid,
	input logic high_valid
);

	// ====================================================================
	// Valid timing
	// ====================================================================

	// Delay line, MAC and combiner each add one register stage.
	a_valid_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid == $past(sample_valid, 3))
		else $error("out_valid does not follow sample_valid through the pipeline");

	a_mac_valids_equal: assert property (@(posedge clk)
		low_valid == high_valid)
		else $error("the two MAC units disagree on sum_valid");

	// ====================================================================
	// Reset and output hold
	// ====================================================================

	a_reset_quiet: assert property (@(posedge clk)
		reset |-> !out_valid)
		else $error("out_valid is high during reset");

	a_hold_output: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> $stable(sample_out))
		else $error("sample_out changed without out_valid");

endmodule

bind fir19_top fir19_props #(.WIDTH(WIDTH)) u_props (
	.clk (clk),
	.reset (reset),
	.sample_valid (sample_valid),
	.out_valid (out_valid),
	.sample_out (sample_out),
	.low_valid (low_valid),
	.high_valid (high_valid)
);

// File: testbench/fir19_tb.sv
`timescale 1ns/1ps

module fir19_tb;
	import fir_pkg::*;

	localparam int WIDTH = SAMPLE_WIDTH;
	localparam int RESET_CYCLES = 4;
	localparam int PIPE_LATENCY = 3;	// Delay line, MAC and combiner registers.

	typedef logic signed [WIDTH-1:0] sample_t;

	localparam sample_t SAMPLE_MAX = {1'b0, {(WIDTH-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(WIDTH-1){1'b0}}};

	logic clk;
	logic reset;
	sample_t sample_in;
	logic sample_valid;
	sample_t sample_out;
	logic out_valid;

	// Stimulus table, one entry per driven row.
	string row_name [$];
	sample_t row_sample [$];
	bit row_valid [$];
	int row_idle [$];
	sample_t row_expected [$];

	sample_t exp_q [$];	// Results still in the pipeline.
	string name_q [$];

	longint model_taps [NUM_TAPS];
	int accepted_count;
	int result_count;
	int cycle_count;
	int cycle_limit;

	fir19_top #(.WIDTH(WIDTH)) u_dut (
		.clk (clk),
		.reset (reset),
		.sample_in (sample_in),
		.sample_valid (sample_valid),
		.sample_out (sample_out),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================================================================
	// Reporting and compare tasks
	// ====================================================================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			report_failure($sformatf("mismatch %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	// ====================================================================
	// Reference model
	// ====================================================================

	// Software delay line, then sum, add half, shift and clamp.
	function automatic sample_t model_step(input sample_t x);
		longint acc;
		longint hi;
		longint lo;
		hi = (longint'(1) <<< (WIDTH - 1)) - 1;
		lo = -(longint'(1) <<< (WIDTH - 1));
		for (int k = NUM_TAPS - 1; k > 0; k--) begin
			model_taps[k] = model_taps[k-1];
		end
		model_taps[0] = longint'(x);
		acc = 0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			acc = acc + model_taps[k] * longint'(FIR_COEFS[k]);
		end
		acc = (acc + (longint'(1) <<< (COEF_FRAC - 1))) >>> COEF_FRAC;
		if (acc > hi) acc = hi;
		if (acc < lo) acc = lo;
		return sample_t'(acc);
	endfunction

	task automatic add_row(input string name, input sample_t sample, input bit valid,
			input int idle);
		row_name.push_back(name);
		row_sample.push_back(sample);
		row_valid.push_back(valid);
		row_idle.push_back(idle);
	endtask

	// ====================================================================
	// Table construction
	// ====================================================================

	task automatic build_table();
		add_row("reset_idle", sample_t'(0), 1'b0, 2);
		add_row("impulse", sample_t'(128), 1'b1, 0);
		repeat (NUM_TAPS - 1) add_row("impulse", sample_t'(0), 1'b1, 0);
		repeat (25) add_row("step", sample_t'(1000), 1'b1, 0);
		for (int k = NUM_TAPS - 1; k >= 0; k--) begin
			add_row("sat_pos", (FIR_COEFS[k] < 0) ? SAMPLE_MIN : SAMPLE_MAX, 1'b1, 0);
		end
		for (int k = NUM_TAPS - 1; k >= 0; k--) begin
			add_row("sat_neg", (FIR_COEFS[k] < 0) ? SAMPLE_MAX : SAMPLE_MIN, 1'b1, 0);
		end
		for (int i = 0; i < 12; i++) begin
			add_row("gaps", sample_t'(i * 500 - 3000), 1'b1, i % 3);
			if (i % 2 == 1) add_row("gaps", sample_t'(-12345), 1'b0, 1);	// Junk, not taken.
		end
		for (int i = 0; i < 200; i++) begin
			add_row("random", sample_t'($urandom()), ($urandom() % 4) != 0,
				(($urandom() % 3) == 0) ? int'($urandom() % 3) : 0);
		end
	endtask

	// Known answers that the model itself must reproduce.
	task automatic check_references();
		int imp_k;
		imp_k = 0;
		for (int i = 0; i < row_name.size(); i++) begin
			if (row_name[i] == "impulse") begin
				check_sample("impulse_ref", sample_t'(FIR_COEFS[imp_k]), row_expected[i]);
				imp_k++;
			end
			if (i + 1 < row_name.size() && row_name[i+1] != row_name[i]) begin
				if (row_name[i] == "step") check_sample("step_ref", sample_t'(1000),
					row_expected[i]);
				if (row_name[i] == "sat_pos") check_sample("sat_pos_ref", SAMPLE_MAX,
					row_expected[i]);
				if (row_name[i] == "sat_neg") check_sample("sat_neg_ref", SAMPLE_MIN,
					row_expected[i]);
			end
		end
	endtask

	// ====================================================================
	// Monitor and watchdog
	// ====================================================================

	always @(posedge clk) begin
		if (!reset && out_valid) begin
			if (exp_q.size() == 0) begin
				report_failure("out_valid was high with no accepted sample outstanding");
			end else begin
				check_sample(name_q.pop_front(), exp_q.pop_front(), sample_out);
				result_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			report_failure("timeout, the filter did not deliver all results in time");
		end
	end

	// ====================================================================
	// Main sequence
	// ====================================================================

	initial begin
		reset = 1'b1;
		sample_in = '0;
		sample_valid = 1'b0;
		accepted_count = 0;
		result_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		void'($urandom(38));
		for (int k = 0; k < NUM_TAPS; k++) model_taps[k] = 0;	// Taps clear on reset.

		build_table();
		cycle_limit = row_name.size() + RESET_CYCLES + 50;
		for (int i = 0; i < row_name.size(); i++) begin
			row_expected.push_back(row_valid[i] ? model_step(row_sample[i]) : sample_t'(0));
			cycle_limit += row_idle[i];
		end
		check_references();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < row_name.size(); i++) begin
			sample_in = row_sample[i];
			sample_valid = row_valid[i];
			if (row_valid[i]) begin
				exp_q.push_back(row_expected[i]);
				name_q.push_back(row_name[i]);
				accepted_count++;
			end
			@(posedge clk);
			#1;
			sample_valid = 1'b0;
			repeat (row_idle[i]) begin
				@(posedge clk);
				#1;
			end
		end

		repeat (PIPE_LATENCY + 2) @(posedge clk);	// Last result plus margin.

		check_count("out_valid_count", accepted_count, result_count);
		$display("Regression passed");
		$finish;
	end

endmodule

// File: filelist.f
rtl/fir_pkg.sv
rtl/tap_bus_if.sv
rtl/tap_delay_line.sv
rtl/partial_mac.sv
rtl/fir_combiner.sv
rtl/fir19_top.sv
testbench/fir19_props.sv
testbench/fir19_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := fir19_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
